// File: rm_consts.svh
`ifndef RM_CONSTS_SVH
`define RM_CONSTS_SVH

// operand and pointer register word
`define DATA_W 16

// physical address on the bus side
`define ADDR_W 16

// register number carried in a command
// widened to ADDR_W before translation
`define REG_NUM_W 6

// command code width
// five ops in use, three codes spare
`define OP_W 3

// regions seen by the translation
//   raw >= unmodifiable boundary  -> used as is
//   raw >= first memory size      -> plus data base
//   anything lower                -> plus process base

`endif

// File: rm_pkg.sv
`default_nettype none

`include "rm_consts.svh"

package rm_pkg;

  // command from the core
  typedef enum logic [`OP_W-1:0] {
    OP_CATCH   = 3'd0,
    OP_READ    = 3'd1,
    OP_READ_P  = 3'd2,
    OP_WRITE   = 3'd3,
    OP_WRITE_P = 3'd4
  } reg_op_e;

  // post step on a plain write
  typedef enum logic [1:0] {
    STEP_NONE = 2'b00,
    STEP_INC  = 2'b01,
    STEP_DEC  = 2'b10
  } step_e;

  // command sequencer
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUS  = 2'd1,
    DONE = 2'd2
  } seq_state_e;

endpackage

`default_nettype wire

// File: addr_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "rm_consts.svh"

module addr_map (
  input  wire  [`ADDR_W-1:0] raw_addr,
  input  wire  [`ADDR_W-1:0] base_addr,
  input  wire  [`ADDR_W-1:0] base_addr_data,
  input  wire  [`ADDR_W-1:0] addr_unmod,
  input  wire  [`ADDR_W-1:0] mem1_size,
  output logic [`ADDR_W-1:0] phys_addr
);

  logic [`ADDR_W-1:0] offset;
  logic               in_fixed;
  logic               in_data;

  // upper region shared by all processes
  assign in_fixed = (raw_addr >= addr_unmod);
  // past the first memory, data segment
  assign in_data  = (raw_addr >= mem1_size);

  always_comb begin
    if (in_fixed) begin
      // absolute address
      offset = '0;
    end else if (in_data) begin
      offset = base_addr_data;
    end else begin
      // low region belongs to the process
      offset = base_addr;
    end
  end

  // wraps at ADDR_W like the bus does
  assign phys_addr = raw_addr + offset;

endmodule

`default_nettype wire

// File: operand_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "rm_consts.svh"

module operand_regs (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   catch_en,
  input  wire                   read_en,
  input  wire                   read_p_en,
  input  wire [`DATA_W-1:0]     alu_result,
  input  wire [`DATA_W-1:0]     bus_data,
  input  wire rm_pkg::reg_op_e  cmd_op,
  input  wire                   is_ptr,
  input  wire rm_pkg::step_e    step,
  output logic [`DATA_W-1:0]    register_value,
  output logic [`DATA_W-1:0]    pointer_value,
  output logic [`DATA_W-1:0]    write_data
);
  import rm_pkg::*;

  logic [`DATA_W-1:0] operand_q;
  logic [`DATA_W-1:0] pointer_q;
  logic [`DATA_W-1:0] wr_src;

  // strobes come one at a time from the sequencer
  always_ff @(posedge clk) begin
    if (rst) begin
      operand_q <= '0;
      pointer_q <= '0;
    end else if (catch_en) begin
      // alu result lands in both
      operand_q <= alu_result;
      pointer_q <= alu_result;
    end else if (read_en) begin
      operand_q <= bus_data;
      pointer_q <= bus_data;
    end else if (read_p_en) begin
      // pointer kept for the next indirect access
      operand_q <= bus_data;
    end
  end

  // plain write may store the pointer instead
  assign wr_src = (cmd_op == OP_WRITE && is_ptr) ? pointer_q : operand_q;

  always_comb begin
    write_data = wr_src;
    if (cmd_op == OP_WRITE) begin
      case (step)
        STEP_INC: write_data = wr_src + 1'b1;
        STEP_DEC: write_data = wr_src - 1'b1;
        default:  write_data = wr_src;
      endcase
    end
  end

  assign register_value = operand_q;
  assign pointer_value  = pointer_q;

endmodule

`default_nettype wire

// File: wb_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "rm_consts.svh"

module wb_master (
  input  wire                clk,
  input  wire                rst,
  input  wire                start,
  input  wire                write,
  input  wire  [`ADDR_W-1:0] addr,
  input  wire  [`DATA_W-1:0] wdata,
  output logic               done,
  output logic [`DATA_W-1:0] rdata,
  output logic               wb_cyc,
  output logic               wb_stb,
  output logic               wb_we,
  output logic [`ADDR_W-1:0] wb_adr,
  output logic [`DATA_W-1:0] wb_dat_w,
  input  wire  [`DATA_W-1:0] wb_dat_r,
  input  wire                wb_ack
);

  logic cyc_q;

  // control side of the transfer
  always_ff @(posedge clk) begin
    if (rst) begin
      cyc_q <= 1'b0;
      wb_we <= 1'b0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (cyc_q && wb_ack) begin
        // single beat, release on the edge after ack
        cyc_q <= 1'b0;
        wb_we <= 1'b0;
        done  <= 1'b1;
      end else if (start && !cyc_q) begin
        cyc_q <= 1'b1;
        wb_we <= write;
      end
    end
  end

  // address and data held steady for the whole cycle
  always_ff @(posedge clk) begin
    if (start && !cyc_q) begin
      wb_adr   <= addr;
      wb_dat_w <= wdata;
    end
    // read word taken on the ack edge
    if (cyc_q && wb_ack) rdata <= wb_dat_r;
  end

  assign wb_cyc = cyc_q;
  assign wb_stb = cyc_q;

endmodule

`default_nettype wire

// File: reg_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rm_consts.svh"

module reg_sequencer (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  cmd_valid,
  input  wire rm_pkg::reg_op_e cmd_op,
  output logic                 cmd_ready,
  output logic                 cmd_done,
  output logic                 catch_en,
  output logic                 read_en,
  output logic                 read_p_en,
  output logic                 addr_sel_ptr,
  output logic                 bus_start,
  output logic                 bus_write,
  input  wire                  bus_done
);
  import rm_pkg::*;

  seq_state_e state_q;
  seq_state_e state_d;
  reg_op_e    op_q;
  logic       take;
  logic       is_bus_op;
  logic       finish;

  // one command in flight
  assign cmd_ready = (state_q == IDLE);
  assign take      = cmd_valid && cmd_ready;

  // op decode
  // only meaningful in the take cycle
  always_comb begin
    is_bus_op    = 1'b0;
    bus_write    = 1'b0;
    addr_sel_ptr = 1'b0;
    case (cmd_op)
      OP_READ: begin
        is_bus_op = 1'b1;
      end
      OP_READ_P: begin
        is_bus_op    = 1'b1;
        addr_sel_ptr = 1'b1;
      end
      OP_WRITE: begin
        is_bus_op = 1'b1;
        bus_write = 1'b1;
      end
      OP_WRITE_P: begin
        is_bus_op    = 1'b1;
        bus_write    = 1'b1;
        addr_sel_ptr = 1'b1;
      end
      default: begin
        // catch and spare codes stay off the bus
        is_bus_op = 1'b0;
      end
    endcase
  end

  // bus port registers address and data on this strobe
  assign bus_start = take && is_bus_op;

  // catch loads on the take edge itself
  assign catch_en = take && (cmd_op == OP_CATCH);

  // loads fire with the bus done pulse
  assign read_en   = (state_q == BUS) && bus_done && (op_q == OP_READ);
  assign read_p_en = (state_q == BUS) && bus_done && (op_q == OP_READ_P);

  // last cycle of a command
  assign finish = ((state_q == BUS) && bus_done) || (state_q == DONE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (take) begin
          if (is_bus_op) begin
            state_d = BUS;
          end else begin
            state_d = DONE;
          end
        end
      end
      BUS: begin
        // stays here as long as the slave holds off ack
        if (bus_done) state_d = IDLE;
      end
      DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= IDLE;
      cmd_done <= 1'b0;
    end else begin
      state_q  <= state_d;
      // pulse lines up with the return to idle
      cmd_done <= finish;
    end
  end

  // op kept for the load decision at bus done
  always_ff @(posedge clk) begin
    if (take) op_q <= cmd_op;
  end

endmodule

`default_nettype wire

// File: register_manager.sv
`timescale 1ns/1ps
`default_nettype none

`include "rm_consts.svh"

module register_manager (
  input  wire                   clk,
  input  wire                   rst,
  // core side
  input  wire                   cmd_valid,
  input  wire rm_pkg::reg_op_e  cmd_op,
  input  wire [`REG_NUM_W-1:0]  reg_num,
  input  wire                   is_ptr,
  input  wire rm_pkg::step_e    step,
  input  wire [`DATA_W-1:0]     alu_result,
  input  wire [`ADDR_W-1:0]     base_addr,
  input  wire [`ADDR_W-1:0]     base_addr_data,
  input  wire [`ADDR_W-1:0]     addr_unmod,
  input  wire [`ADDR_W-1:0]     mem1_size,
  output logic                  cmd_ready,
  output logic                  cmd_done,
  output logic [`DATA_W-1:0]    register_value,
  output logic [`DATA_W-1:0]    pointer_value,
  // wishbone master
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output logic [`ADDR_W-1:0]    wb_adr,
  output logic [`DATA_W-1:0]    wb_dat_w,
  input  wire [`DATA_W-1:0]     wb_dat_r,
  input  wire                   wb_ack
);

  logic               catch_en;
  logic               read_en;
  logic               read_p_en;
  logic               addr_sel_ptr;
  logic               bus_start;
  logic               bus_write;
  logic               bus_done;
  logic [`DATA_W-1:0] bus_rdata;
  logic [`DATA_W-1:0] write_data;
  logic [`ADDR_W-1:0] raw_addr;
  logic [`ADDR_W-1:0] phys_addr;

  reg_sequencer u_seq (
    .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
    .cmd_ready(cmd_ready), .cmd_done(cmd_done),
    .catch_en(catch_en), .read_en(read_en), .read_p_en(read_p_en),
    .addr_sel_ptr(addr_sel_ptr), .bus_start(bus_start), .bus_write(bus_write),
    .bus_done(bus_done)
  );

  operand_regs u_regs (
    .clk(clk), .rst(rst), .catch_en(catch_en), .read_en(read_en), .read_p_en(read_p_en),
    .alu_result(alu_result), .bus_data(bus_rdata), .cmd_op(cmd_op), .is_ptr(is_ptr),
    .step(step), .register_value(register_value), .pointer_value(pointer_value),
    .write_data(write_data)
  );

  // pointer or zero extended register number
  assign raw_addr = addr_sel_ptr ? `ADDR_W'(pointer_value) : `ADDR_W'(reg_num);

  addr_map u_map (
    .raw_addr(raw_addr), .base_addr(base_addr), .base_addr_data(base_addr_data),
    .addr_unmod(addr_unmod), .mem1_size(mem1_size), .phys_addr(phys_addr)
  );

  wb_master u_wb (
    .clk(clk), .rst(rst), .start(bus_start), .write(bus_write), .addr(phys_addr),
    .wdata(write_data), .done(bus_done), .rdata(bus_rdata),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

endmodule

`default_nettype wire

// File: rm_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "rm_consts.svh"

module rm_chk (
  input wire                  clk,
  input wire                  rst,
  input wire                  cmd_valid,
  input wire rm_pkg::reg_op_e cmd_op,
  input wire                  cmd_ready,
  input wire                  cmd_done,
  input wire                  wb_cyc,
  input wire                  wb_stb,
  input wire                  wb_we,
  input wire [`ADDR_W-1:0]    wb_adr,
  input wire [`DATA_W-1:0]    wb_dat_w,
  input wire                  wb_ack
);
  import rm_pkg::*;

  // failed assertions so far
  int assert_errs = 0;

  // request held steady while the slave waits
  a_hold: assert property (@(posedge clk) disable iff (rst)
    (wb_cyc && wb_stb && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr)
      && $stable(wb_we) && $stable(wb_dat_w)))
    else begin
      $error("wishbone request changed before ack");
      assert_errs++;
    end

  // single beat
  // released right after ack
  a_release: assert property (@(posedge clk) disable iff (rst)
    (wb_cyc && wb_stb && wb_ack) |=> (!wb_cyc && !wb_stb))
    else begin
      $error("wishbone cycle not released after ack");
      assert_errs++;
    end

  // bus ops raise cyc and stb together on the cycle after the take
  a_start: assert property (@(posedge clk) disable iff (rst)
    (cmd_valid && cmd_ready && (cmd_op inside {OP_READ, OP_READ_P, OP_WRITE, OP_WRITE_P}))
      |=> (wb_cyc && wb_stb))
    else begin
      $error("bus op did not start a wishbone cycle after take");
      assert_errs++;
    end

  // done follows the ack edge by one cycle
  a_done_lat: assert property (@(posedge clk) disable iff (rst)
    (wb_cyc && wb_stb && wb_ack) |-> ##2 cmd_done)
    else begin
      $error("cmd_done not one cycle after ack");
      assert_errs++;
    end

  a_busy: assert property (@(posedge clk) disable iff (rst)
    (cmd_valid && cmd_ready) |=> !cmd_ready)
    else begin
      $error("cmd_ready high right after take");
      assert_errs++;
    end

  // no bus cycle while idle
  a_bus_busy: assert property (@(posedge clk) disable iff (rst) wb_cyc |-> !cmd_ready)
    else begin
      $error("cmd_ready high during bus cycle");
      assert_errs++;
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (rst) cmd_done |=> !cmd_done)
    else begin
      $error("cmd_done longer than one cycle");
      assert_errs++;
    end

endmodule

`default_nettype wire

// File: tb_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "rm_consts.svh"

module tb_monitor (
  input wire               clk,
  input wire               rst,
  input wire               cmd_valid,
  input wire               cmd_ready,
  input wire               cmd_done,
  input wire [`DATA_W-1:0] register_value,
  input wire [`DATA_W-1:0] pointer_value,
  input wire               wb_cyc,
  input wire               wb_stb,
  input wire               wb_we,
  input wire [`ADDR_W-1:0] wb_adr,
  input wire [`DATA_W-1:0] wb_dat_w,
  input wire               wb_ack,
  input wire [31:0]        test_num,
  input wire [2:0]         exp_op,
  input wire [`ADDR_W-1:0] exp_adr,
  input wire [`DATA_W-1:0] exp_wdata,
  input wire [`DATA_W-1:0] exp_reg,
  input wire [`DATA_W-1:0] exp_ptr,
  output int               pass_count,
  output int               fail_count,
  output int               done_count
);

  int   cycle = 0;
  int   take_cycle = 0;
  int   xfer_count = 0;
  int   test_errs = 0;
  logic busy = 1'b0;
  logic rst_seen = 1'b0;
  logic exp_we;

  // op codes 3 and 4 are the two writes
  assign exp_we = (exp_op == 3'd3) || (exp_op == 3'd4);

  task automatic compare_word(input string what, input logic [15:0] got,
                              input logic [15:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t ns: test %0d %s got %h expected %h", $time, test_num, what, got, exp);
      test_errs++;
    end
  endtask

  task automatic close_test(input string name);
    if (test_errs == 0) begin
      $display("PASS %0t ns: %s", $time, name);
      pass_count++;
    end else begin
      $display("FAIL %0t ns: %s with %0d errors", $time, name, test_errs);
      fail_count++;
    end
  endtask

  initial begin
    pass_count = 0;
    fail_count = 0;
    done_count = 0;
  end

  // everything sampled on the rising edge, inputs move on the falling one
  always @(posedge clk) begin
    cycle++;
    if (rst) begin
      rst_seen = 1'b1;
      busy = 1'b0;
    end else begin
      if (rst_seen) begin
        rst_seen = 1'b0;
        test_errs = 0;
        compare_word("cmd_ready after reset", 16'(cmd_ready), 16'd1);
        compare_word("bus idle after reset", {13'd0, wb_cyc, wb_stb, wb_we}, 16'd0);
        compare_word("cmd_done after reset", 16'(cmd_done), 16'd0);
        close_test("reset state");
      end
      if (busy && cmd_ready && !cmd_done) begin
        $display("test %0d: cmd_ready went high before cmd_done", test_num);
        test_errs++;
      end
      // one transfer completes on its ack edge
      if (wb_cyc && wb_stb && wb_ack) begin
        xfer_count++;
        compare_word("wb_we", 16'(wb_we), 16'(exp_we));
        compare_word("wb_adr", wb_adr, exp_adr);
        if (exp_we) compare_word("wb_dat_w", wb_dat_w, exp_wdata);
      end
      if (cmd_done) begin
        done_count++;
        compare_word("register_value", register_value, exp_reg);
        compare_word("pointer_value", pointer_value, exp_ptr);
        if (exp_op == 3'd0 && (cycle - take_cycle) != 2) begin
          $display("test %0d: catch finished %0d cycles after take instead of 2",
                   test_num, cycle - take_cycle);
          test_errs++;
        end
        if (xfer_count != ((exp_op == 3'd0) ? 0 : 1)) begin
          $display("test %0d: saw %0d bus transfers for this command", test_num, xfer_count);
          test_errs++;
        end
        busy = 1'b0;
        close_test($sformatf("test %0d op %0d", test_num, exp_op));
      end
      if (cmd_valid && cmd_ready) begin
        busy = 1'b1;
        take_cycle = cycle;
        xfer_count = 0;
        test_errs = 0;
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_register_manager.sv
`timescale 1ns/1ps
`default_nettype none

`include "rm_consts.svh"

module tb_register_manager;

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 16;
  localparam int MEM_DEPTH = 256;
  localparam int SEED = 29;
  localparam int NUM_TESTS = 16;
  localparam int VEC_WORDS = 12;
  localparam int IMG_WORDS = MEM_DEPTH + NUM_TESTS * VEC_WORDS;
  // take, bus rise, up to three wait states, done, gap
  localparam int CMD_CYCLES = 11;
  localparam int WATCHDOG_NS = (RST_CYCLES + 8 + NUM_TESTS * CMD_CYCLES) * CLK_PERIOD;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  cmd_valid;
  rm_pkg::reg_op_e       cmd_op;
  logic [`REG_NUM_W-1:0] reg_num;
  logic                  is_ptr;
  rm_pkg::step_e         step;
  logic [`DATA_W-1:0]    alu_result;
  logic [`ADDR_W-1:0]    base_addr;
  logic [`ADDR_W-1:0]    base_addr_data;
  logic [`ADDR_W-1:0]    addr_unmod;
  logic [`ADDR_W-1:0]    mem1_size;
  logic                  cmd_ready;
  logic                  cmd_done;
  logic [`DATA_W-1:0]    register_value;
  logic [`DATA_W-1:0]    pointer_value;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [`ADDR_W-1:0]    wb_adr;
  logic [`DATA_W-1:0]    wb_dat_w;
  logic [`DATA_W-1:0]    wb_dat_r;
  logic                  wb_ack;

  // expected values handed to the monitor
  logic [31:0]        test_num;
  logic [2:0]         exp_op;
  logic [`ADDR_W-1:0] exp_adr;
  logic [`DATA_W-1:0] exp_wdata;
  logic [`DATA_W-1:0] exp_reg;
  logic [`DATA_W-1:0] exp_ptr;
  int                 pass_count;
  int                 fail_count;
  int                 done_count;

  logic [15:0] image [0:IMG_WORDS-1];
  logic [15:0] mem [0:MEM_DEPTH-1];
  logic [31:0] lcg_state = 32'(SEED);
  logic [1:0]  ack_wait = 2'd0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  register_manager UUT (.*);

  tb_monitor mon (
    .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .cmd_done(cmd_done), .register_value(register_value), .pointer_value(pointer_value),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .test_num(test_num), .exp_op(exp_op),
    .exp_adr(exp_adr), .exp_wdata(exp_wdata), .exp_reg(exp_reg), .exp_ptr(exp_ptr),
    .pass_count(pass_count), .fail_count(fail_count), .done_count(done_count)
  );

  bind register_manager rm_chk chk (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return 32'(s * 32'd1103515245 + 32'd12345);
  endfunction

  // slave with 0 to 3 wait states
  // upper lcg bits pick the delay
  always @(negedge clk) begin
    if (wb_ack) begin
      wb_ack = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (ack_wait == 2'd0) begin
        if (wb_we) mem[wb_adr[7:0]] = wb_dat_w;
        wb_dat_r = mem[wb_adr[7:0]];
        wb_ack = 1'b1;
      end else begin
        ack_wait = ack_wait - 2'd1;
      end
    end else begin
      lcg_state = lcg_next(lcg_state);
      ack_wait = lcg_state[17:16];
    end
  end

  task automatic load_vector(input int k);
    int b;
    b = MEM_DEPTH + k * VEC_WORDS;
    test_num = 32'(k + 1);
    exp_op = image[b][2:0];
    cmd_op = rm_pkg::reg_op_e'(image[b][2:0]);
    is_ptr = image[b + 1][2];
    step = rm_pkg::step_e'(image[b + 1][1:0]);
    reg_num = image[b + 2][`REG_NUM_W-1:0];
    alu_result = image[b + 3];
    base_addr = image[b + 4];
    base_addr_data = image[b + 5];
    addr_unmod = image[b + 6];
    mem1_size = image[b + 7];
    exp_adr = image[b + 8];
    exp_reg = image[b + 9];
    exp_ptr = image[b + 10];
    exp_wdata = image[b + 11];
  endtask

  task automatic run_command(input int k);
    @(negedge clk);
    while (!cmd_ready) @(negedge clk);
    load_vector(k);
    cmd_valid = 1'b1;
    @(negedge clk);
    cmd_valid = 1'b0;
    while (!cmd_done) @(negedge clk);
    // monitor closes the test on the next edge
    @(negedge clk);
  endtask

  initial begin
    rst = 1'b1;
    cmd_valid = 1'b0;
    cmd_op = rm_pkg::OP_CATCH;
    reg_num = '0;
    is_ptr = 1'b0;
    step = rm_pkg::STEP_NONE;
    alu_result = '0;
    base_addr = '0;
    base_addr_data = '0;
    addr_unmod = '0;
    mem1_size = '0;
    wb_dat_r = '0;
    wb_ack = 1'b0;
    test_num = '0;
    exp_op = '0;
    exp_adr = '0;
    exp_wdata = '0;
    exp_reg = '0;
    exp_ptr = '0;
    for (int i = 0; i < IMG_WORDS; i++) begin
      image[i] = (i < MEM_DEPTH) ? {~8'(i), 8'(i)} : 16'h0000;
    end
    $readmemh("rm_testdata.mem", image);
    for (int i = 0; i < MEM_DEPTH; i++) mem[i] = image[i];
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    for (int k = 0; k < NUM_TESTS; k++) run_command(k);
    repeat (2) @(negedge clk);
    $display("tests passed %0d, failed %0d, commands done %0d of %0d, assertion failures %0d",
             pass_count, fail_count, done_count, NUM_TESTS, UUT.chk.assert_errs);
    if (fail_count == 0 && done_count == NUM_TESTS && UUT.chk.assert_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: commands still pending after %0d ns", WATCHDOG_NS);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: rm_testdata.mem
// preload: @addr then memory words, every other word keeps the address fill pattern
// vectors at @0100, 12 words each: op flags reg_num alu base base_data unmod mem1 adr reg ptr wdata
@0035 0007
@0047 BEEF
@0055 0010
@00B5 0033
@0100
// flags: bit 2 is_ptr, bits 1:0 step (1 inc, 2 dec)
0 0 00 1234 0040 0080 0030 0020 0000 1234 1234 0000
1 0 05 0000 0050 0080 0030 0020 0055 0010 0010 0000
1 0 25 0000 0040 0090 0030 0020 00B5 0033 0033 0000
1 0 35 0000 0040 0080 0030 0020 0035 0007 0007 0000
2 0 00 0000 0040 0080 0030 0020 0047 BEEF 0007 0000
3 1 09 0000 0040 0080 0030 0020 0049 BEEF 0007 BEF0
3 6 26 0000 0040 0080 0030 0020 00A6 BEEF 0007 0006
3 0 3A 0000 0040 0080 0030 0020 003A BEEF 0007 BEEF
3 4 0A 0000 0040 0080 0030 0020 004A BEEF 0007 0007
0 0 00 0028 0040 0080 0030 0020 0000 0028 0028 0000
4 0 00 0000 0040 0080 0030 0020 00A8 0028 0028 0028
1 0 26 0000 0040 0080 0030 0020 00A6 0006 0006 0000
0 0 00 0049 0040 0080 0030 0020 0000 0049 0049 0000
2 0 00 0000 0040 0080 0030 0020 0049 BEF0 0049 0000
3 2 3B 0000 0040 0080 0030 0020 003B BEF0 0049 BEEF
1 0 3B 0000 0040 0080 0030 0020 003B BEEF BEEF 0000

// File: files.f
+incdir+.
rm_pkg.sv
addr_map.sv
operand_regs.sv
wb_master.sv
reg_sequencer.sv
register_manager.sv
rm_chk.sv
tb_monitor.sv
tb_register_manager.sv

// File: Makefile
TOOL      := verilator
TOP       := tb_register_manager
RTL_TOP   := register_manager
FILELIST  := files.f
RTL_FILES := rm_pkg.sv addr_map.sv operand_regs.sv wb_master.sv reg_sequencer.sv \
             register_manager.sv
LINT_FLAGS := --lint-only +incdir+.
SIM_FLAGS  := --binary --timing --assert
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
